// File: source/husky_config.svh
`ifndef HUSKY_CONFIG_SVH
`define HUSKY_CONFIG_SVH

// Register map
`define REG_TARGET_CTRL     8'h20
`define REG_IO_CTRL         8'h21
`define REG_FIFO_CTRL       8'h30
`define REG_FIFO_STATUS     8'h31
`define REG_FIFO_DATA       8'h32

`define TC_AVRPROG          0
`define TC_NRST_EN          1
`define TC_NRST_VAL         2
`define TC_POWER_OFF        3

`define IO_PDID_EN          0
`define IO_PDID_VAL         1
`define IO_PDIC_EN          2
`define IO_PDIC_VAL         3

`define FC_SRC_LA           0   // Source select, reads back
`define FC_FLUSH            1   // Pulse, reads as 0
`define FC_CLR_ERR          2   // Pulse, reads as 0

`define FS_EMPTY            0
`define FS_FULL             1
`define FS_OVERFLOW         2
`define FS_UNDERFLOW        3

`define FIFO_DEPTH          16
`define FIFO_BYTES_PER_WORD 3
`define FLASH_DIV_BITS      4

`endif

// File: source/husky_pkg.sv
package husky_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   typedef logic [17:0] fifo_word_t;

   // Which producer owns the capture FIFO
   typedef enum logic {
      FIFO_SRC_TRACE = 1'b0,
      FIFO_SRC_LA    = 1'b1
   } fifo_src_e;

   // Register bus sequencer
   typedef enum logic [1:0] {
      BUS_IDLE      = 2'd0,
      BUS_WRITE     = 2'd1,
      BUS_READ_WAIT = 2'd2,
      BUS_READ_HOLD = 2'd3
   } bus_state_e;

endpackage

// File: source/usb_reg_bus.sv
`timescale 1ns/1ps

module usb_reg_bus (
   input  logic                 clk_usb_buf,
   input  logic                 rst_i,
   input  husky_pkg::reg_addr_t usb_addr_i,
   input  husky_pkg::reg_data_t usb_data_i,
   input  logic                 usb_cen_i,
   input  logic                 usb_rdn_i,
   input  logic                 usb_wrn_i,
   output husky_pkg::reg_data_t usb_data_o,
   output logic                 usb_data_oe_o,
   output husky_pkg::reg_addr_t reg_addr_o,
   output husky_pkg::reg_data_t reg_wdata_o,
   output logic                 reg_read_o,
   output logic                 reg_write_o,
   input  husky_pkg::reg_data_t rdata_ctrl_i,
   input  husky_pkg::reg_data_t rdata_fifo_i
);
   import husky_pkg::*;

   logic [1:0] cen_sync_q;   // [1] is the synchronized level
   logic [1:0] rdn_sync_q;
   logic [1:0] wrn_sync_q;
   logic       rdn_prev_q;
   logic       wrn_prev_q;
   logic       read_dly_q;
   logic       cen_act;
   logic       rd_fall;
   logic       wr_fall;
   bus_state_e state_q;

   // Host strobes are idle high
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         cen_sync_q <= 2'b11;
         rdn_sync_q <= 2'b11;
         wrn_sync_q <= 2'b11;
         rdn_prev_q <= 1'b1;
         wrn_prev_q <= 1'b1;
      end else begin
         cen_sync_q <= {cen_sync_q[0], usb_cen_i};
         rdn_sync_q <= {rdn_sync_q[0], usb_rdn_i};
         wrn_sync_q <= {wrn_sync_q[0], usb_wrn_i};
         rdn_prev_q <= rdn_sync_q[1];
         wrn_prev_q <= wrn_sync_q[1];
      end
   end

   assign cen_act = ~cen_sync_q[1];
   assign rd_fall = rdn_prev_q & ~rdn_sync_q[1];
   assign wr_fall = wrn_prev_q & ~wrn_sync_q[1];

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state_q       <= BUS_IDLE;
         reg_read_o    <= 1'b0;
         reg_write_o   <= 1'b0;
         read_dly_q    <= 1'b0;
         usb_data_oe_o <= 1'b0;
         usb_data_o    <= '0;
         reg_addr_o    <= '0;
         reg_wdata_o   <= '0;
      end else begin
         reg_read_o  <= 1'b0;        // Pulses last one cycle
         reg_write_o <= 1'b0;
         read_dly_q  <= reg_read_o;
         case (state_q)
            BUS_IDLE: begin
               if (cen_act && rd_fall) begin
                  reg_addr_o <= usb_addr_i;
                  reg_read_o <= 1'b1;
                  state_q    <= BUS_READ_WAIT;
               end else if (cen_act && wr_fall) begin
                  reg_addr_o  <= usb_addr_i;
                  reg_wdata_o <= usb_data_i;
                  reg_write_o <= 1'b1;
                  state_q     <= BUS_WRITE;
               end
            end
            BUS_WRITE: begin
               if (wrn_sync_q[1])
                  state_q <= BUS_IDLE;
            end
            // Blocks need a cycle after the pulse to load read registers
            BUS_READ_WAIT: begin
               if (read_dly_q) begin
                  usb_data_o    <= rdata_ctrl_i | rdata_fifo_i;
                  usb_data_oe_o <= 1'b1;
                  state_q       <= BUS_READ_HOLD;
               end
            end
            BUS_READ_HOLD: begin
               if (rdn_sync_q[0]) begin   // Synchronized rdn rises this edge
                  usb_data_oe_o <= 1'b0;
                  state_q       <= BUS_IDLE;
               end
            end
            default: state_q <= BUS_IDLE;
         endcase
      end
   end

endmodule

// File: source/reg_target_ctrl.sv
`include "husky_config.svh"
`timescale 1ns/1ps

module reg_target_ctrl (
   input  logic                 clk_usb_buf,
   input  logic                 rst_i,
   input  husky_pkg::reg_addr_t reg_addr_i,
   input  husky_pkg::reg_data_t reg_wdata_i,
   input  logic                 reg_write_i,
   input  logic                 avr_nrst_i,
   input  logic                 sam_mosi_i,
   input  logic                 sam_spck_i,
   input  logic                 target_miso_i,
   output husky_pkg::reg_data_t rdata_o,
   output logic                 target_nrst_o,
   output logic                 target_nrst_oe_o,
   output logic                 target_mosi_o,
   output logic                 target_mosi_oe_o,
   output logic                 target_sck_o,
   output logic                 target_sck_oe_o,
   output logic                 target_pdid_o,
   output logic                 target_pdid_oe_o,
   output logic                 target_pdic_o,
   output logic                 target_pdic_oe_o,
   output logic                 sam_miso_o,
   output logic                 sam_miso_oe_o,
   output logic                 target_poweron_o
);

   logic [3:0] target_ctrl_q;
   logic [3:0] io_ctrl_q;
   logic       power_off;
   logic       avrprog;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         target_ctrl_q <= 4'h0;
         io_ctrl_q     <= 4'h0;
      end else if (reg_write_i) begin
         if (reg_addr_i == `REG_TARGET_CTRL)
            target_ctrl_q <= reg_wdata_i[3:0];
         if (reg_addr_i == `REG_IO_CTRL)
            io_ctrl_q <= reg_wdata_i[3:0];
      end
   end

   always_comb begin
      case (reg_addr_i)
         `REG_TARGET_CTRL: rdata_o = {4'h0, target_ctrl_q};
         `REG_IO_CTRL:     rdata_o = {4'h0, io_ctrl_q};
         default:          rdata_o = 8'h00;
      endcase
   end

   assign power_off        = target_ctrl_q[`TC_POWER_OFF];
   assign avrprog          = target_ctrl_q[`TC_AVRPROG];
   assign target_poweron_o = ~power_off;

   // AVR programming owns nRST ahead of the manual setting
   assign target_nrst_oe_o = ~power_off & (avrprog | target_ctrl_q[`TC_NRST_EN]);
   assign target_nrst_o    = target_nrst_oe_o &
                             (avrprog ? avr_nrst_i : target_ctrl_q[`TC_NRST_VAL]);

   assign target_mosi_oe_o = ~power_off & avrprog;
   assign target_mosi_o    = target_mosi_oe_o & sam_mosi_i;
   assign target_sck_oe_o  = ~power_off & avrprog;
   assign target_sck_o     = target_sck_oe_o & sam_spck_i;

   assign target_pdid_oe_o = ~power_off & io_ctrl_q[`IO_PDID_EN];
   assign target_pdid_o    = target_pdid_oe_o & io_ctrl_q[`IO_PDID_VAL];
   assign target_pdic_oe_o = ~power_off & io_ctrl_q[`IO_PDIC_EN];
   assign target_pdic_o    = target_pdic_oe_o & io_ctrl_q[`IO_PDIC_VAL];

   // MISO goes back to the SAM even with target power off
   assign sam_miso_oe_o = avrprog;
   assign sam_miso_o    = avrprog & target_miso_i;

endmodule

// File: source/capture_fifo.sv
`include "husky_config.svh"
`timescale 1ns/1ps

module capture_fifo (
   input  logic                  clk_usb_buf,
   input  logic                  rst_i,
   input  husky_pkg::reg_addr_t  reg_addr_i,
   input  husky_pkg::reg_data_t  reg_wdata_i,
   input  logic                  reg_read_i,
   input  logic                  reg_write_i,
   input  logic                  trace_wr_i,
   input  husky_pkg::fifo_word_t trace_data_i,
   input  logic                  la_wr_i,
   input  husky_pkg::fifo_word_t la_data_i,
   output husky_pkg::reg_data_t  rdata_o,
   output logic                  fifo_error_o
);
   import husky_pkg::*;

   localparam int DEPTH = `FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   fifo_word_t       mem [DEPTH];
   fifo_src_e        src_q;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic [1:0]       byte_idx_q;
   reg_data_t        rd_byte_q;     // Presented on REG_FIFO_DATA
   logic             overflow_q;
   logic             underflow_q;
   logic             empty;
   logic             full;
   logic             sel_wr;
   fifo_word_t       sel_data;
   logic             push;
   logic             pop;
   logic             data_rd;
   logic             ctrl_wr;
   fifo_word_t       head_word;
   reg_data_t        head_byte;

   assign empty    = (count_q == '0);
   assign full     = (count_q == (PTR_W+1)'(DEPTH));
   assign sel_wr   = (src_q == FIFO_SRC_LA) ? la_wr_i : trace_wr_i;
   assign sel_data = (src_q == FIFO_SRC_LA) ? la_data_i : trace_data_i;
   assign push     = sel_wr & ~full;   // Writes to a full FIFO are dropped
   assign data_rd  = reg_read_i && (reg_addr_i == `REG_FIFO_DATA);
   assign ctrl_wr  = reg_write_i && (reg_addr_i == `REG_FIFO_CTRL);
   assign pop      = data_rd & ~empty &
                     (byte_idx_q == 2'(`FIFO_BYTES_PER_WORD - 1));

   assign head_word = mem[rd_ptr_q];

   always_comb begin
      case (byte_idx_q)
         2'd0:    head_byte = head_word[7:0];
         2'd1:    head_byte = head_word[15:8];
         default: head_byte = {6'b0, head_word[17:16]};
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push)
         mem[wr_ptr_q] <= sel_data;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i)
         rd_byte_q <= 8'h00;
      else if (data_rd)
         rd_byte_q <= empty ? 8'h00 : head_byte;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         src_q       <= FIFO_SRC_TRACE;
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         byte_idx_q  <= 2'd0;
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         if (ctrl_wr)
            src_q <= fifo_src_e'(reg_wdata_i[`FC_SRC_LA]);

         if (ctrl_wr && reg_wdata_i[`FC_FLUSH]) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            byte_idx_q <= 2'd0;
         end else begin
            if (push)
               wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
               rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop)
               count_q <= count_q + 1'b1;
            else if (pop && !push)
               count_q <= count_q - 1'b1;
            if (data_rd && !empty)
               byte_idx_q <= pop ? 2'd0 : byte_idx_q + 2'd1;
         end

         if (ctrl_wr && reg_wdata_i[`FC_CLR_ERR]) begin
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
         end
         if (sel_wr && full)
            overflow_q <= 1'b1;    // A new error wins over a clear
         if (data_rd && empty)
            underflow_q <= 1'b1;
      end
   end

   always_comb begin
      rdata_o = 8'h00;
      case (reg_addr_i)
         `REG_FIFO_CTRL: rdata_o[`FC_SRC_LA] = (src_q == FIFO_SRC_LA);
         `REG_FIFO_STATUS: begin
            rdata_o[`FS_EMPTY]     = empty;
            rdata_o[`FS_FULL]      = full;
            rdata_o[`FS_OVERFLOW]  = overflow_q;
            rdata_o[`FS_UNDERFLOW] = underflow_q;
         end
         `REG_FIFO_DATA: rdata_o = rd_byte_q;
         default: rdata_o = 8'h00;
      endcase
   end

   assign fifo_error_o = overflow_q | underflow_q;

endmodule

// File: source/status_led.sv
`include "husky_config.svh"
`timescale 1ns/1ps

module status_led (
   input  logic clk_usb_buf,
   input  logic rst_i,
   input  logic error_i,
   input  logic pll_status_i,
   output logic led_adc_o
);

   // Top bit toggles every 2**FLASH_DIV_BITS cycles
   logic [`FLASH_DIV_BITS:0] flash_cnt_q;
   logic                     flash_pattern;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         flash_cnt_q <= '0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
      end
   end

   assign flash_pattern = flash_cnt_q[`FLASH_DIV_BITS];

   // Fast flash on an internal error, PLL lock otherwise
   assign led_adc_o = error_i ? flash_pattern : ~pll_status_i;

endmodule

// File: source/husky_top.sv
`timescale 1ns/1ps

module husky_top (
   input  logic                  clk_usb_buf,
   input  logic                  rst_i,
   input  husky_pkg::reg_addr_t  usb_addr_i,
   input  husky_pkg::reg_data_t  usb_data_i,
   input  logic                  usb_cen_i,
   input  logic                  usb_rdn_i,
   input  logic                  usb_wrn_i,
   output husky_pkg::reg_data_t  usb_data_o,
   output logic                  usb_data_oe_o,
   input  logic                  avr_nrst_i,
   input  logic                  sam_mosi_i,
   input  logic                  sam_spck_i,
   input  logic                  target_miso_i,
   output logic                  target_nrst_o,
   output logic                  target_nrst_oe_o,
   output logic                  target_mosi_o,
   output logic                  target_mosi_oe_o,
   output logic                  target_sck_o,
   output logic                  target_sck_oe_o,
   output logic                  target_pdid_o,
   output logic                  target_pdid_oe_o,
   output logic                  target_pdic_o,
   output logic                  target_pdic_oe_o,
   output logic                  sam_miso_o,
   output logic                  sam_miso_oe_o,
   output logic                  target_poweron_o,
   input  logic                  trace_wr_i,
   input  husky_pkg::fifo_word_t trace_data_i,
   input  logic                  la_wr_i,
   input  husky_pkg::fifo_word_t la_data_i,
   input  logic                  pll_status_i,
   output logic                  led_adc_o
);
   import husky_pkg::*;

   reg_addr_t reg_addr;
   reg_data_t reg_wdata;
   logic      reg_read;
   logic      reg_write;
   reg_data_t rdata_ctrl;
   reg_data_t rdata_fifo;
   logic      fifo_error;

   usb_reg_bus u_bus (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_cen_i     (usb_cen_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_addr_o    (reg_addr),
      .reg_wdata_o   (reg_wdata),
      .reg_read_o    (reg_read),
      .reg_write_o   (reg_write),
      .rdata_ctrl_i  (rdata_ctrl),
      .rdata_fifo_i  (rdata_fifo)
   );

   reg_target_ctrl u_target (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .avr_nrst_i       (avr_nrst_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (rdata_ctrl),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o),
      .target_poweron_o (target_poweron_o)
   );

   // Shared by trace and LA producers
   capture_fifo u_fifo (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .reg_read_i   (reg_read),
      .reg_write_i  (reg_write),
      .trace_wr_i   (trace_wr_i),
      .trace_data_i (trace_data_i),
      .la_wr_i      (la_wr_i),
      .la_data_i    (la_data_i),
      .rdata_o      (rdata_fifo),
      .fifo_error_o (fifo_error)
   );

   status_led u_led (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .error_i      (fifo_error),
      .pll_status_i (pll_status_i),
      .led_adc_o    (led_adc_o)
   );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   // Free running, first rising edge at half a period
   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: sim/husky_top_asserts.sv
`timescale 1ns/1ps

module husky_top_asserts (
   input logic clk_usb_buf,
   input logic rst_i,
   input logic reg_read_i,
   input logic reg_write_i,
   input logic usb_rdn_i,
   input logic usb_data_oe_i
);

   // Sequencer issues one register pulse at a time
   a_read_write_exclusive: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      !(reg_read_i && reg_write_i))
      else $error("reg_read and reg_write were high together");

   a_write_one_cycle: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      reg_write_i |=> !reg_write_i)
      else $error("reg_write lasted more than one cycle");

   // Bus only drives while the host holds rdn low
   a_oe_needs_rdn: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      usb_data_oe_i |-> !$past(usb_rdn_i, 2))
      else $error("usb_data_oe_o high without rdn low two cycles before");

endmodule

bind husky_top husky_top_asserts u_asserts (
   .clk_usb_buf   (clk_usb_buf),
   .rst_i         (rst_i),
   .reg_read_i    (reg_read),
   .reg_write_i   (reg_write),
   .usb_rdn_i     (usb_rdn_i),
   .usb_data_oe_i (usb_data_oe_o)
);

// File: sim/tb_husky_top.sv
`timescale 1ns/1ps
`include "husky_config.svh"

module tb_husky_top;
   import husky_pkg::*;

   localparam int unsigned SEED        = 32'h8b49_ae20;
   localparam int unsigned BUS_TIMEOUT = 40;
   localparam int unsigned LED_TIMEOUT = 80;   // Flash period is 32 cycles

   logic       clk_usb_buf;
   logic       rst;
   reg_addr_t  usb_addr;
   reg_data_t  usb_data_in;
   logic       usb_cen;
   logic       usb_rdn;
   logic       usb_wrn;
   reg_data_t  usb_data_out;
   logic       usb_data_oe;
   logic       avr_nrst;
   logic       sam_mosi;
   logic       sam_spck;
   logic       target_miso;
   logic       target_nrst;
   logic       target_nrst_oe;
   logic       target_mosi;
   logic       target_mosi_oe;
   logic       target_sck;
   logic       target_sck_oe;
   logic       target_pdid;
   logic       target_pdid_oe;
   logic       target_pdic;
   logic       target_pdic_oe;
   logic       sam_miso;
   logic       sam_miso_oe;
   logic       target_poweron;
   logic       trace_wr;
   fifo_word_t trace_data;
   logic       la_wr;
   fifo_word_t la_data;
   logic       pll_status;
   logic       led_adc;

   fifo_word_t  model_q[$];   // Expected FIFO contents
   logic        model_ovf;
   logic        model_unf;
   fifo_src_e   cur_src;
   int unsigned seed_val;

   tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk_o(clk_usb_buf));

   husky_top u_dut (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_data_in),
      .usb_cen_i        (usb_cen),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_data_o       (usb_data_out),
      .usb_data_oe_o    (usb_data_oe),
      .avr_nrst_i       (avr_nrst),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .target_nrst_o    (target_nrst),
      .target_nrst_oe_o (target_nrst_oe),
      .target_mosi_o    (target_mosi),
      .target_mosi_oe_o (target_mosi_oe),
      .target_sck_o     (target_sck),
      .target_sck_oe_o  (target_sck_oe),
      .target_pdid_o    (target_pdid),
      .target_pdid_oe_o (target_pdid_oe),
      .target_pdic_o    (target_pdic),
      .target_pdic_oe_o (target_pdic_oe),
      .sam_miso_o       (sam_miso),
      .sam_miso_oe_o    (sam_miso_oe),
      .target_poweron_o (target_poweron),
      .trace_wr_i       (trace_wr),
      .trace_data_i     (trace_data),
      .la_wr_i          (la_wr),
      .la_data_i        (la_data),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      if (act !== exp)
         fail_run($sformatf("Mismatch in %s: expected 0x%02h, actual 0x%02h", name, exp, act));
   endtask

   task automatic check_word(input string name, input fifo_word_t exp, input fifo_word_t act);
      if (act !== exp)
         fail_run($sformatf("Mismatch in %s: expected 0x%05h, actual 0x%05h", name, exp, act));
   endtask

   task automatic check_pin(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
   endtask

   function automatic reg_data_t fifo_ctrl_byte(input fifo_src_e src, input logic flush,
                                                input logic clr);
      reg_data_t b;
      b              = 8'h00;
      b[`FC_SRC_LA]  = (src == FIFO_SRC_LA);
      b[`FC_FLUSH]   = flush;
      b[`FC_CLR_ERR] = clr;
      return b;
   endfunction

   // Status as the model sees it
   function automatic reg_data_t expected_status();
      reg_data_t b;
      b                = 8'h00;
      b[`FS_EMPTY]     = (model_q.size() == 0);
      b[`FS_FULL]      = (model_q.size() == `FIFO_DEPTH);
      b[`FS_OVERFLOW]  = model_ovf;
      b[`FS_UNDERFLOW] = model_unf;
      return b;
   endfunction

   task automatic host_write(input reg_addr_t addr, input reg_data_t data);
      int unsigned n;
      @(negedge clk_usb_buf);
      usb_addr    = addr;
      usb_data_in = data;
      usb_cen     = 1'b0;
      @(negedge clk_usb_buf);
      usb_wrn = 1'b0;
      n = 0;
      while (!u_dut.reg_write) begin
         @(negedge clk_usb_buf);
         n++;
         if (n >= BUS_TIMEOUT)
            fail_run("No register write pulse after the write strobe fell");
      end
      usb_wrn = 1'b1;
      usb_cen = 1'b1;
      n = 0;
      while (u_dut.u_bus.state_q != BUS_IDLE) begin   // Wait for wrn to sync back
         @(negedge clk_usb_buf);
         n++;
         if (n >= BUS_TIMEOUT)
            fail_run("Register bus did not return to idle after a write");
      end
   endtask

   task automatic host_read(input reg_addr_t addr, output reg_data_t data);
      int unsigned n;
      @(negedge clk_usb_buf);
      usb_addr = addr;
      usb_cen  = 1'b0;
      @(negedge clk_usb_buf);
      usb_rdn = 1'b0;
      n = 0;
      while (!usb_data_oe) begin
         @(negedge clk_usb_buf);
         n++;
         if (n >= BUS_TIMEOUT)
            fail_run("usb_data_oe_o did not rise after the read strobe fell");
      end
      data    = usb_data_out;
      usb_rdn = 1'b1;
      usb_cen = 1'b1;
      n = 0;
      while (usb_data_oe) begin
         @(negedge clk_usb_buf);
         n++;
         if (n >= BUS_TIMEOUT)
            fail_run("usb_data_oe_o stayed high after the read strobe rose");
      end
   endtask

   task automatic check_status(input string name);
      reg_data_t rd;
      host_read(`REG_FIFO_STATUS, rd);
      check_data(name, expected_status(), rd);
   endtask

   task automatic model_push(input fifo_word_t w);
      if (model_q.size() < `FIFO_DEPTH)
         model_q.push_back(w);
      else
         model_ovf = 1'b1;   // Dropped word
   endtask

   // Random strobes on both ports, the selected one optionally forced
   task automatic drive_producers(input fifo_src_e src, input int cycles, input logic force_sel);
      logic       sel_wr;
      fifo_word_t sel_word;
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk_usb_buf);
         trace_wr   = 1'($urandom);
         trace_data = 18'($urandom);
         la_wr      = 1'($urandom);
         la_data    = 18'($urandom);
         if (force_sel && src == FIFO_SRC_LA)
            la_wr = 1'b1;
         if (force_sel && src == FIFO_SRC_TRACE)
            trace_wr = 1'b1;
         sel_wr   = (src == FIFO_SRC_LA) ? la_wr : trace_wr;
         sel_word = (src == FIFO_SRC_LA) ? la_data : trace_data;
         if (sel_wr)
            model_push(sel_word);
      end
      @(negedge clk_usb_buf);
      trace_wr = 1'b0;
      la_wr    = 1'b0;
   endtask

   task automatic check_fifo_word(input string name);
      reg_data_t  b0;
      reg_data_t  b1;
      reg_data_t  b2;
      fifo_word_t exp;
      exp = model_q.pop_front();
      host_read(`REG_FIFO_DATA, b0);
      host_read(`REG_FIFO_DATA, b1);
      host_read(`REG_FIFO_DATA, b2);
      check_data({name, " top byte"}, {6'b0, exp[17:16]}, b2);
      check_word(name, exp, {b2[1:0], b1, b0});
   endtask

   task automatic check_empty_read(input string name);
      reg_data_t rd;
      host_read(`REG_FIFO_DATA, rd);
      model_unf = 1'b1;
      check_data(name, 8'h00, rd);
   endtask

   task automatic select_source(input fifo_src_e src);
      reg_data_t rd;
      cur_src = src;
      host_write(`REG_FIFO_CTRL, fifo_ctrl_byte(src, 1'b1, 1'b0));
      model_q.delete();
      host_read(`REG_FIFO_CTRL, rd);   // Flush bit never reads back
      check_data("fifo ctrl readback", fifo_ctrl_byte(src, 1'b0, 1'b0), rd);
   endtask

   task automatic clear_errors();
      host_write(`REG_FIFO_CTRL, fifo_ctrl_byte(cur_src, 1'b0, 1'b1));
      model_ovf = 1'b0;
      model_unf = 1'b0;
   endtask

   task automatic wait_led(input logic level);
      int unsigned n;
      n = 0;
      while (led_adc !== level) begin
         @(negedge clk_usb_buf);
         n++;
         if (n >= LED_TIMEOUT)
            fail_run($sformatf("led_adc_o never reached %0b during an error", level));
      end
   endtask

   task automatic check_pins(input logic [3:0] tc, input logic [3:0] io);
      logic powered;
      logic avrprog;
      logic nrst_drive;
      logic nrst_val;
      powered    = !tc[`TC_POWER_OFF];
      avrprog    = tc[`TC_AVRPROG];
      nrst_drive = avrprog || tc[`TC_NRST_EN];
      nrst_val   = avrprog ? avr_nrst : tc[`TC_NRST_VAL];   // AVR programming first
      check_pin("target_poweron", powered, target_poweron);
      check_pin("nrst enable", powered && nrst_drive, target_nrst_oe);
      if (powered && nrst_drive)
         check_pin("nrst value", nrst_val, target_nrst);
      check_pin("mosi enable", powered && avrprog, target_mosi_oe);
      check_pin("sck enable", powered && avrprog, target_sck_oe);
      if (powered && avrprog) begin
         check_pin("mosi value", sam_mosi, target_mosi);
         check_pin("sck value", sam_spck, target_sck);
      end
      check_pin("pdid enable", powered && io[`IO_PDID_EN], target_pdid_oe);
      if (powered && io[`IO_PDID_EN])
         check_pin("pdid value", io[`IO_PDID_VAL], target_pdid);
      check_pin("pdic enable", powered && io[`IO_PDIC_EN], target_pdic_oe);
      if (powered && io[`IO_PDIC_EN])
         check_pin("pdic value", io[`IO_PDIC_VAL], target_pdic);
      check_pin("miso enable", avrprog, sam_miso_oe);   // Independent of power
      if (avrprog)
         check_pin("miso value", target_miso, sam_miso);
   endtask

   task automatic test_reg_readback();
      reg_data_t v_tc;
      reg_data_t v_io;
      reg_data_t rd;
      for (int i = 0; i < 4; i++) begin
         v_tc = 8'($urandom);
         v_io = 8'($urandom);
         host_write(`REG_TARGET_CTRL, v_tc);
         host_write(`REG_IO_CTRL, v_io);
         host_read(`REG_TARGET_CTRL, rd);
         check_data("target ctrl readback", v_tc & 8'h0f, rd);
         host_read(`REG_IO_CTRL, rd);
         check_data("io ctrl readback", v_io & 8'h0f, rd);
      end
   endtask

   task automatic test_pins();
      logic [3:0] tc;
      logic [3:0] io;
      for (int i = 0; i < 50; i++) begin
         tc = 4'($urandom);
         io = 4'($urandom);
         host_write(`REG_TARGET_CTRL, {4'h0, tc});
         host_write(`REG_IO_CTRL, {4'h0, io});
         @(negedge clk_usb_buf);
         avr_nrst    = 1'($urandom);
         sam_mosi    = 1'($urandom);
         sam_spck    = 1'($urandom);
         target_miso = 1'($urandom);
         @(negedge clk_usb_buf);
         check_pins(tc, io);
      end
      host_write(`REG_TARGET_CTRL, 8'h00);
   endtask

   task automatic test_fifo_stream();
      select_source(fifo_src_e'(1'($urandom)));
      drive_producers(cur_src, 20, 1'b0);
      check_status("status after stream");
      while (model_q.size() > 0)
         check_fifo_word("stream word");
      check_status("status after drain");
   endtask

   task automatic test_fifo_full();
      select_source(fifo_src_e'(1'($urandom)));
      drive_producers(cur_src, 18, 1'b1);
      check_status("status when full");
      wait_led(1'b1);
      wait_led(1'b0);
      clear_errors();
      pll_status = 1'($urandom);
      @(negedge clk_usb_buf);
      check_pin("led after clear", ~pll_status, led_adc);
      pll_status = ~pll_status;
      @(negedge clk_usb_buf);
      check_pin("led after pll change", ~pll_status, led_adc);
      while (model_q.size() > 0)
         check_fifo_word("full fifo word");
      check_empty_read("read while empty");
      check_status("status after underflow");
   endtask

   task automatic test_fifo_flush();
      clear_errors();
      drive_producers(cur_src, $urandom_range(10, 3), 1'b1);
      check_status("status before flush");
      host_write(`REG_FIFO_CTRL, fifo_ctrl_byte(cur_src, 1'b1, 1'b0));
      model_q.delete();
      check_status("status after flush");
      check_empty_read("read after flush");
      check_status("status after flush read");
   endtask

   initial begin
      seed_val    = $urandom(SEED);
      rst         = 1'b1;
      usb_addr    = '0;
      usb_data_in = '0;
      usb_cen     = 1'b1;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      avr_nrst    = 1'b1;
      sam_mosi    = 1'b0;
      sam_spck    = 1'b0;
      target_miso = 1'b0;
      trace_wr    = 1'b0;
      trace_data  = '0;
      la_wr       = 1'b0;
      la_data     = '0;
      pll_status  = 1'b1;
      model_ovf   = 1'b0;
      model_unf   = 1'b0;
      cur_src     = FIFO_SRC_TRACE;
      for (int i = 0; i < 10; i++)
         @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      rst = 1'b0;
      @(negedge clk_usb_buf);
      check_pin("poweron after reset", 1'b1, target_poweron);
      check_pin("nrst enable after reset", 1'b0, target_nrst_oe);
      check_pin("data oe after reset", 1'b0, usb_data_oe);
      check_status("status after reset");
      test_reg_readback();
      test_pins();
      test_fifo_stream();
      test_fifo_full();
      test_fifo_flush();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+source
source/husky_pkg.sv
source/usb_reg_bus.sv
source/reg_target_ctrl.sv
source/capture_fifo.sv
source/status_led.sv
source/husky_top.sv
sim/tb_clock_gen.sv
sim/husky_top_asserts.sv
sim/tb_husky_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_husky_top -f filelist.f -o sim_husky

./obj_dir/sim_husky 2>&1 | tee sim.log

if grep -qF "=== PASS ===" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
